//--- wb_trace.txt
# L: v0 rd0 data0 pc0 inst0 exc0 badv0 v1 rd1 data1 pc1 inst1 exc1 badv1 redir_v redir_pc
# W: csr wdata, R: reg expected, C: csr expected, all fields hex
L 1 01 11111111 1c000000 02800421 00 0 1 02 22222222 1c000004 02800842 00 0 0 0
R 01 11111111
R 02 22222222
L 1 03 aaaa0003 1c000008 02800c63 00 0 1 03 bbbb0003 1c00000c 02800c63 00 0 0 0
R 03 bbbb0003
L 1 00 deadbeef 1c000010 02800000 00 0 1 00 cafef00d 1c000014 02800000 00 0 0 0
R 00 00000000
W 00c 1c008000
W 088 1c00f000
W 019 00a00000
W 01a 00b00000
W 000 00000017
C 00c 1c008000
C 088 1c00f000
C 000 00000017
L 1 04 44444444 1c000100 28800085 01 80012345 1 05 55555555 1c000104 028014a5 00 0 1 1c008000
R 04 00000000
R 05 00000000
C 006 1c000100
C 005 00010000
C 007 80012345
C 011 80012000
C 01b 00b00000
C 001 00000007
C 000 00000010
L 1 08 0 1c000200 28c00108 09 00001ffc 0 0 0 0 0 00 0 1 1c008000
C 007 00001ffc
C 011 80012000
C 01b 00a00000
C 005 00090000
C 001 00000000
L 1 00 0 1c000300 002b0000 0b 12345678 1 06 66666666 1c000304 02801806 00 0 1 1c008000
R 06 00000000
C 007 00001ffc
C 011 80012000
C 005 000b0000
C 006 1c000300
W 000 00000017
L 1 00 0 1c000400 06482000 3f 7fffe123 0 0 0 0 0 00 0 1 1c00f000
C 000 00000008
C 001 00000007
C 005 003f0000
C 011 7fffe000
L 1 00 0 1c000500 28800000 48 00000003 0 0 0 0 0 00 0 1 1c008000
C 005 00480000
C 007 00000003
W 3ff 12345678
C 3ff 00000000
L 0 00 0 0 0 00 0 1 07 77777777 1c000600 02801ce7 00 0 0 0
R 07 77777777

//--- tb.f
wb_pkg.sv
writeback.sv
register_file.sv
csr_unit.sv
wb_subsystem.sv
tb_wb_subsystem.sv

//--- Makefile
# Verilator build for the writeback subsystem testbench.

TOP       ?= tb_wb_subsystem
TRACE     ?= wb_trace.txt
LOG       ?= sim.log
FILELIST  ?= tb.f
BUILD     ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: compile $(TRACE)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_wb_subsystem.sv
`timescale 1ns/100ps

module tb_wb_subsystem;

    localparam int half_period   = 50;
    localparam int reset_cycles  = 8;
    localparam int max_records   = 400;
    localparam int filler_cycles = 64;
    localparam int limit_cycles  = 2000;

    logic                  clk;
    logic                  reset;
    wb_pkg::lane_result_t  lane0;
    wb_pkg::lane_result_t  lane1;
    logic                  csr_we;
    logic [13:0]           csr_wnum;
    logic [31:0]           csr_wdata;
    logic [13:0]           csr_raddr;
    logic [31:0]           csr_rdata;
    logic [4:0]            rf_raddr0;
    logic [4:0]            rf_raddr1;
    logic [31:0]           rf_rdata0;
    logic [31:0]           rf_rdata1;
    logic                  redirect_valid;
    logic [31:0]           redirect_pc;
    wb_pkg::debug_commit_t debug0;
    wb_pkg::debug_commit_t debug1;

    int          errors;
    int          checks;
    logic [31:0] shadow [0:31];  // predicted register file.
    logic [31:0] seed;

    wb_subsystem wb_subsystem_inst (
        .clk            (clk),
        .reset          (reset),
        .lane0          (lane0),
        .lane1          (lane1),
        .csr_we         (csr_we),
        .csr_wnum       (csr_wnum),
        .csr_wdata      (csr_wdata),
        .csr_raddr      (csr_raddr),
        .csr_rdata      (csr_rdata),
        .rf_raddr0      (rf_raddr0),
        .rf_raddr1      (rf_raddr1),
        .rf_rdata0      (rf_rdata0),
        .rf_rdata1      (rf_rdata1),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .debug0         (debug0),
        .debug1         (debug1)
    );

    always #half_period clk = ~clk;

    ////////////////////
    // helpers.
    ////////////////////
    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic wb_pkg::lane_result_t make_lane(input logic [31:0] v, input logic [31:0] rd,
            input logic [31:0] data, input logic [31:0] pc, input logic [31:0] inst,
            input logic [31:0] exc, input logic [31:0] badv);
        wb_pkg::lane_result_t lane;
        lane.valid     = v[0];
        lane.rd        = rd[4:0];
        lane.data      = data;
        lane.pc        = pc;
        lane.inst      = inst;
        lane.exception = exc[6:0];
        lane.badv      = badv;
        return lane;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic idle_inputs;
        lane0  = '0;
        lane1  = '0;
        csr_we = 1'b0;
    endtask

    task automatic check_debug(input string name, input wb_pkg::lane_result_t lane,
            input logic commit, input wb_pkg::debug_commit_t dbg);
        check_value({name, ".pc"}, lane.pc, dbg.pc);
        check_value({name, ".inst"}, lane.inst, dbg.inst);
        check_value({name, ".rf_wnum"}, {27'b0, lane.rd}, {27'b0, dbg.rf_wnum});
        check_value({name, ".rf_wdata"}, lane.data, dbg.rf_wdata);
        check_value({name, ".rf_wen"}, {28'b0, commit ? 4'hf : 4'h0}, {28'b0, dbg.rf_wen});
    endtask

    // lane 0 fault squashes both lanes.
    task automatic check_lanes(input logic exp_valid, input logic [31:0] exp_pc);
        logic fault0;
        logic commit0;
        logic commit1;
        fault0  = lane0.valid && (lane0.exception != wb_pkg::exp_none);
        commit0 = lane0.valid && !fault0;
        commit1 = lane1.valid && !fault0;
        check_value("redirect_valid", {31'b0, exp_valid}, {31'b0, redirect_valid});
        if (exp_valid) begin
            check_value("redirect_pc", exp_pc, redirect_pc);
        end
        check_debug("debug0", lane0, commit0, debug0);
        check_debug("debug1", lane1, commit1, debug1);
        if (commit0 && lane0.rd != 5'd0) begin
            shadow[lane0.rd] = lane0.data;
        end
        if (commit1 && lane1.rd != 5'd0) begin
            shadow[lane1.rd] = lane1.data;  // younger lane wins.
        end
    endtask

    task automatic run_record(input string line);
        logic [7:0]  kind;
        string       rest;
        int          n;
        int          want;
        logic [31:0] f [0:15];
        kind = line.getc(0);
        rest = line.substr(2, line.len() - 1);
        want = 2;
        n    = 0;
        case (kind)
            "L": begin
                want = 16;
                n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                if (n == want) begin
                    lane0 = make_lane(f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    lane1 = make_lane(f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                    #(half_period / 2);
                    check_lanes(f[14][0], f[15]);
                end
            end
            "W": begin
                n = $sscanf(rest, "%h %h", f[0], f[1]);
                csr_we    = 1'b1;
                csr_wnum  = f[0][13:0];
                csr_wdata = f[1];
            end
            "R": begin
                n = $sscanf(rest, "%h %h", f[0], f[1]);
                rf_raddr0 = f[0][4:0];
                #(half_period / 2);
                check_value($sformatf("r%0d", f[0][4:0]), f[1], rf_rdata0);
            end
            "C": begin
                n = $sscanf(rest, "%h %h", f[0], f[1]);
                csr_raddr = f[0][13:0];
                #(half_period / 2);
                check_value($sformatf("csr 0x%03h", f[0][13:0]), f[1], csr_rdata);
            end
            default: begin
                n = want;
                errors++;
                $display("trace line has an unknown record kind: %s", line);
            end
        endcase
        if (n != want) begin
            errors++;
            $display("trace line could not be parsed: %s", line);
        end
    endtask

    task automatic finish_run;
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    ////////////////////
    // stimulus.
    ////////////////////
    initial begin
        int         fd;
        int         records;
        string      line;
        logic [4:0] prev_rd0;
        logic [4:0] prev_rd1;
        clk       = 1'b0;
        reset     = 1'b1;
        csr_wnum  = '0;
        csr_wdata = '0;
        csr_raddr = '0;
        rf_raddr0 = '0;
        rf_raddr1 = '0;
        idle_inputs();
        errors    = 0;
        checks    = 0;
        seed      = 32'ha79e_8272;
        prev_rd0  = '0;
        prev_rd1  = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset     = 1'b0;
        csr_raddr = wb_pkg::csr_crmd;
        #(half_period / 2);
        check_value("reset crmd", 32'h0000_0008, csr_rdata);
        check_value("reset redirect_valid", 32'h0, {31'b0, redirect_valid});
        check_value("reset debug0.rf_wen", 32'h0, {28'b0, debug0.rf_wen});
        check_value("reset debug1.rf_wen", 32'h0, {28'b0, debug1.rf_wen});

        fd = $fopen("wb_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("trace file wb_trace.txt could not be opened");
        end else begin
            records = 0;
            while (!$feof(fd) && records < max_records) begin
                if ($fgets(line, fd) > 1 && line.getc(0) != "#") begin
                    records++;
                    @(negedge clk);
                    idle_inputs();
                    run_record(line);
                end
            end
            if (!$feof(fd)) begin
                errors++;
                $display("trace holds more records than the limit allows");
            end
            $fclose(fd);
        end

        // random filler whose reads trail the writes by one cycle.
        for (int i = 0; i < filler_cycles; i++) begin
            @(negedge clk);
            idle_inputs();
            seed  = next_random(seed);
            lane0 = make_lane(32'd1, {27'b0, seed[20:16]}, next_random(seed),
                              32'h1c00_1000 + (i << 3), 32'h0280_0000, 32'd0, 32'd0);
            seed  = next_random(next_random(seed));
            lane1 = make_lane(32'd1, {27'b0, seed[20:16]}, next_random(seed),
                              32'h1c00_1004 + (i << 3), 32'h0280_0000, 32'd0, 32'd0);
            seed      = next_random(seed);
            rf_raddr0 = prev_rd0;
            rf_raddr1 = prev_rd1;
            #(half_period / 2);
            if (i > 0) begin
                check_value("filler rdata0", shadow[prev_rd0], rf_rdata0);
                check_value("filler rdata1", shadow[prev_rd1], rf_rdata1);
            end
            check_lanes(1'b0, 32'h0);
            prev_rd0 = lane0.rd;
            prev_rd1 = lane1.rd;
        end

        // closing sweep of the whole register file.
        for (int r = 0; r < 32; r += 2) begin
            @(negedge clk);
            idle_inputs();
            rf_raddr0 = 5'(r);
            rf_raddr1 = 5'(r + 1);
            #(half_period / 2);
            check_value($sformatf("sweep r%0d", r), shadow[r], rf_rdata0);
            check_value($sformatf("sweep r%0d", r + 1), shadow[r + 1], rf_rdata1);
        end
        finish_run();
    end

    initial begin
        #(2 * half_period * limit_cycles);
        errors++;
        $display("simulation timed out before the test reached its end");
        finish_run();
    end

endmodule

//--- wb_subsystem.sv
`timescale 1ns/100ps

module wb_subsystem (
    input  logic                  clk,
    input  logic                  reset,

    input  wb_pkg::lane_result_t  lane0,
    input  wb_pkg::lane_result_t  lane1,

    input  logic                  csr_we,
    input  logic [13:0]           csr_wnum,
    input  logic [31:0]           csr_wdata,
    input  logic [13:0]           csr_raddr,
    output logic [31:0]           csr_rdata,

    input  logic [4:0]            rf_raddr0,
    input  logic [4:0]            rf_raddr1,
    output logic [31:0]           rf_rdata0,
    output logic [31:0]           rf_rdata1,

    output logic                  redirect_valid,
    output logic [31:0]           redirect_pc,

    output wb_pkg::debug_commit_t debug0,
    output wb_pkg::debug_commit_t debug1
);

    logic             wen0;
    logic             wen1;
    logic [4:0]       waddr0;
    logic [4:0]       waddr1;
    logic [31:0]      wdata0;
    logic [31:0]      wdata1;
    wb_pkg::csr_exc_t exc;
    logic [31:0]      eentry;
    logic [31:0]      tlbrentry;

    ////////////////////
    // writeback stage.
    ////////////////////
    writeback writeback_inst (
        .lane0          (lane0),
        .lane1          (lane1),
        .eentry         (eentry),
        .tlbrentry      (tlbrentry),
        .wen0           (wen0),
        .wen1           (wen1),
        .waddr0         (waddr0),
        .waddr1         (waddr1),
        .wdata0         (wdata0),
        .wdata1         (wdata1),
        .exc            (exc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .debug0         (debug0),
        .debug1         (debug1)
    );

    register_file register_file_inst (
        .clk    (clk),
        .reset  (reset),
        .wen0   (wen0),
        .waddr0 (waddr0),
        .wdata0 (wdata0),
        .wen1   (wen1),
        .waddr1 (waddr1),
        .wdata1 (wdata1),
        .raddr0 (rf_raddr0),
        .rdata0 (rf_rdata0),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1)
    );

    // pgd selection is consumed inside the csr unit.
    csr_unit csr_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .exc       (exc),
        .we        (csr_we),
        .wnum      (csr_wnum),
        .wdata     (csr_wdata),
        .raddr     (csr_raddr),
        .rdata     (csr_rdata),
        .eentry    (eentry),
        .tlbrentry (tlbrentry),
        .pgd_sel   ()
    );

endmodule

//--- csr_unit.sv
`timescale 1ns/100ps

module csr_unit (
    input  logic             clk,
    input  logic             reset,

    input  wb_pkg::csr_exc_t exc,

    input  logic             we,
    input  logic [13:0]      wnum,
    input  logic [31:0]      wdata,

    input  logic [13:0]      raddr,
    output logic [31:0]      rdata,

    output logic [31:0]      eentry,
    output logic [31:0]      tlbrentry,
    output logic [31:0]      pgd_sel
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] badv;
    logic [31:0] tlbehi;
    logic [31:0] pgdl;
    logic [31:0] pgdh;
    logic [31:0] pgd;

    // page table base by address half.
    assign pgd_sel = exc.badv[31] ? pgdh : pgdl;

    ////////////////////
    // register update.
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd      <= wb_pkg::crmd_reset;
            prmd      <= '0;
            estat     <= '0;
            era       <= '0;
            badv      <= '0;
            eentry    <= '0;
            tlbehi    <= '0;
            pgdl      <= '0;
            pgdh      <= '0;
            pgd       <= '0;
            tlbrentry <= '0;
        end else begin
            if (we) begin
                case (wnum)
                    wb_pkg::csr_crmd:      crmd      <= wdata;
                    wb_pkg::csr_prmd:      prmd      <= wdata;
                    wb_pkg::csr_estat:     estat     <= wdata;
                    wb_pkg::csr_era:       era       <= wdata;
                    wb_pkg::csr_badv:      badv      <= wdata;
                    wb_pkg::csr_eentry:    eentry    <= wdata;
                    wb_pkg::csr_tlbehi:    tlbehi    <= wdata;
                    wb_pkg::csr_pgdl:      pgdl      <= wdata;
                    wb_pkg::csr_pgdh:      pgdh      <= wdata;
                    wb_pkg::csr_pgd:       pgd       <= wdata;
                    wb_pkg::csr_tlbrentry: tlbrentry <= wdata;
                    default:               ;
                endcase
            end

            // exception fields override a software write.
            if (exc.take) begin
                prmd[wb_pkg::prmd_pplv +: 2] <= crmd[wb_pkg::crmd_plv +: 2];
                prmd[wb_pkg::prmd_pie]       <= crmd[wb_pkg::crmd_ie];
                crmd[wb_pkg::crmd_plv +: 2]  <= 2'b00;  // kernel mode.
                crmd[wb_pkg::crmd_ie]        <= 1'b0;
                if (exc.to_direct) begin
                    crmd[wb_pkg::crmd_da] <= 1'b1;
                    crmd[wb_pkg::crmd_pg] <= 1'b0;
                end
                estat[wb_pkg::estat_ecode +: 6] <= exc.expcode[5:0];
                estat[wb_pkg::estat_esubcode]   <= exc.expcode[6];
                era <= exc.era;
                if (exc.badv_we) begin
                    badv <= exc.badv;
                end
                if (exc.vppn_we) begin
                    tlbehi[wb_pkg::tlbehi_vppn +: 19] <= exc.vppn;
                end
                if (exc.pgd_we) begin
                    pgd <= pgd_sel;
                end
            end
        end
    end

    ////////////////////
    // read port.
    ////////////////////
    always_comb begin
        case (raddr)
            wb_pkg::csr_crmd:      rdata = crmd;
            wb_pkg::csr_prmd:      rdata = prmd;
            wb_pkg::csr_estat:     rdata = estat;
            wb_pkg::csr_era:       rdata = era;
            wb_pkg::csr_badv:      rdata = badv;
            wb_pkg::csr_eentry:    rdata = eentry;
            wb_pkg::csr_tlbehi:    rdata = tlbehi;
            wb_pkg::csr_pgdl:      rdata = pgdl;
            wb_pkg::csr_pgdh:      rdata = pgdh;
            wb_pkg::csr_pgd:       rdata = pgd;
            wb_pkg::csr_tlbrentry: rdata = tlbrentry;
            default:               rdata = '0;  // unknown csr.
        endcase
    end

endmodule

//--- register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic        clk,
    input  logic        reset,

    input  logic        wen0,
    input  logic [4:0]  waddr0,
    input  logic [31:0] wdata0,
    input  logic        wen1,
    input  logic [4:0]  waddr1,
    input  logic [31:0] wdata1,

    input  logic [4:0]  raddr0,
    output logic [31:0] rdata0,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1
);

    logic [31:0] regs [1:31];  // r0 has no storage.

    ////////////////////
    // write ports.
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen0 && (waddr0 != 5'd0)) begin
                regs[waddr0] <= wdata0;
            end
            // port 1 is the younger instruction.
            if (wen1 && (waddr1 != 5'd0)) begin
                regs[waddr1] <= wdata1;
            end
        end
    end

    ////////////////////
    // read ports.
    ////////////////////
    always_comb begin
        if (raddr0 == 5'd0) begin
            rdata0 = '0;
        end else begin
            rdata0 = regs[raddr0];
        end
    end

    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

endmodule

//--- writeback.sv
`timescale 1ns/100ps

module writeback (
    input  wb_pkg::lane_result_t  lane0,
    input  wb_pkg::lane_result_t  lane1,
    input  logic [31:0]           eentry,
    input  logic [31:0]           tlbrentry,

    output logic                  wen0,
    output logic                  wen1,
    output logic [4:0]            waddr0,
    output logic [4:0]            waddr1,
    output logic [31:0]           wdata0,
    output logic [31:0]           wdata1,

    output wb_pkg::csr_exc_t      exc,

    output logic                  redirect_valid,
    output logic [31:0]           redirect_pc,

    output wb_pkg::debug_commit_t debug0,
    output wb_pkg::debug_commit_t debug1
);

    logic has_exception;
    logic is_tlbr;
    logic set_badv;
    logic set_vppn;

    assign has_exception = lane0.valid && (lane0.exception != wb_pkg::exp_none);
    assign is_tlbr       = lane0.exception == wb_pkg::exp_tlbr;

    // which faults carry a bad address.
    always_comb begin
        set_badv = 1'b0;
        set_vppn = 1'b0;
        if (has_exception) begin
            case (lane0.exception)
                wb_pkg::exp_tlbr, wb_pkg::exp_pil, wb_pkg::exp_pis,
                wb_pkg::exp_pif, wb_pkg::exp_pme, wb_pkg::exp_ppi: begin
                    set_badv = 1'b1;
                    set_vppn = 1'b1;
                end
                wb_pkg::exp_adef, wb_pkg::exp_adem, wb_pkg::exp_ale: begin
                    set_badv = 1'b1;
                end
                default: begin
                    set_badv = 1'b0;
                    set_vppn = 1'b0;
                end
            endcase
        end
    end

    ////////////////////
    // register file writes.
    ////////////////////
    assign wen0   = lane0.valid && (lane0.exception == wb_pkg::exp_none);
    assign wen1   = lane1.valid && !has_exception;  // squashed behind lane 0 fault.
    assign waddr0 = lane0.rd;
    assign waddr1 = lane1.rd;
    assign wdata0 = lane0.data;
    assign wdata1 = lane1.data;

    ////////////////////
    // exception and redirect.
    ////////////////////
    assign redirect_valid = has_exception;
    assign redirect_pc    = is_tlbr ? tlbrentry : eentry;

    assign exc.take      = has_exception;
    assign exc.to_direct = has_exception && is_tlbr; // refill runs untranslated.
    assign exc.era       = lane0.pc;
    assign exc.expcode   = lane0.exception;
    assign exc.badv_we   = set_badv;
    assign exc.badv      = lane0.badv;
    assign exc.vppn_we   = set_vppn;
    assign exc.vppn      = lane0.badv[31:13];
    assign exc.pgd_we    = set_badv;

    ////////////////////
    // debug trace.
    ////////////////////
    assign debug0.pc       = lane0.pc;
    assign debug0.rf_wen   = {4{wen0}};
    assign debug0.rf_wnum  = lane0.rd;
    assign debug0.rf_wdata = lane0.data;
    assign debug0.inst     = lane0.inst;

    assign debug1.pc       = lane1.pc;
    assign debug1.rf_wen   = {4{wen1}};
    assign debug1.rf_wnum  = lane1.rd;
    assign debug1.rf_wdata = lane1.data;
    assign debug1.inst     = lane1.inst;

endmodule

//--- wb_pkg.sv
package wb_pkg;

    ////////////////////
    // exception codes with esubcode in bit 6.
    ////////////////////
    localparam logic [6:0] exp_none = 7'h00;
    localparam logic [6:0] exp_pil  = 7'h01;  // load page invalid.
    localparam logic [6:0] exp_pis  = 7'h02;  // store page invalid.
    localparam logic [6:0] exp_pif  = 7'h03;  // fetch page invalid.
    localparam logic [6:0] exp_pme  = 7'h04;  // page modify.
    localparam logic [6:0] exp_ppi  = 7'h07;  // privilege level.
    localparam logic [6:0] exp_adef = 7'h08;
    localparam logic [6:0] exp_adem = 7'h48;  // same ecode as adef.
    localparam logic [6:0] exp_ale  = 7'h09;
    localparam logic [6:0] exp_sys  = 7'h0b;
    localparam logic [6:0] exp_brk  = 7'h0c;
    localparam logic [6:0] exp_ine  = 7'h0d;
    localparam logic [6:0] exp_tlbr = 7'h3f;

    ////////////////////
    // csr numbers.
    ////////////////////
    localparam logic [13:0] csr_crmd      = 14'h000;
    localparam logic [13:0] csr_prmd      = 14'h001;
    localparam logic [13:0] csr_estat     = 14'h005;
    localparam logic [13:0] csr_era       = 14'h006;
    localparam logic [13:0] csr_badv      = 14'h007;
    localparam logic [13:0] csr_eentry    = 14'h00c;
    localparam logic [13:0] csr_tlbehi    = 14'h011;
    localparam logic [13:0] csr_pgdl      = 14'h019;
    localparam logic [13:0] csr_pgdh      = 14'h01a;
    localparam logic [13:0] csr_pgd       = 14'h01b;
    localparam logic [13:0] csr_tlbrentry = 14'h088;

    ////////////////////
    // csr field layout.
    ////////////////////
    localparam int crmd_plv       = 0;  // two bits.
    localparam int crmd_ie        = 2;
    localparam int crmd_da        = 3;
    localparam int crmd_pg        = 4;
    localparam int prmd_pplv      = 0;  // two bits.
    localparam int prmd_pie       = 2;
    localparam int estat_ecode    = 16; // six bits.
    localparam int estat_esubcode = 22;
    localparam int tlbehi_vppn    = 13; // nineteen bits.

    localparam logic [31:0] crmd_reset = 32'h0000_0008; // da set, plv 0.

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [6:0]  exception;
        logic [31:0] badv;
    } lane_result_t;

    typedef struct packed {
        logic        take;
        logic        to_direct;
        logic [31:0] era;
        logic [6:0]  expcode;
        logic        badv_we;
        logic [31:0] badv;
        logic        vppn_we;
        logic [18:0] vppn;
        logic        pgd_we;
    } csr_exc_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  rf_wen;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
        logic [31:0] inst;
    } debug_commit_t;

endpackage
